//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- axi_lite_if.sv
`timescale 1ns/100ps
`default_nettype none

interface axi_lite_if;
	import mem_pkg::*;

	// read address
	logic              arvalid;
	logic              arready;
	logic [addr_w-1:0] araddr;

	// read data
	logic              rvalid;
	logic              rready;
	logic [data_w-1:0] rdata;
	logic [1:0]        rresp;

	// write address
	logic              awvalid;
	logic              awready;
	logic [addr_w-1:0] awaddr;

	// write data, byte lanes picked by wstrb
	logic              wvalid;
	logic              wready;
	logic [data_w-1:0] wdata;
	logic [strb_w-1:0] wstrb;

	// write response
	logic              bvalid;
	logic              bready;
	logic [1:0]        bresp;

	modport master (
		output arvalid, araddr, input arready,
		input rvalid, rdata, rresp, output rready,
		output awvalid, awaddr, input awready,
		output wvalid, wdata, wstrb, input wready,
		input bvalid, bresp, output bready
	);

	modport slave (
		input arvalid, araddr, output arready,
		output rvalid, rdata, rresp, input rready,
		input awvalid, awaddr, output awready,
		input wvalid, wdata, wstrb, output wready,
		output bvalid, bresp, input bready
	);

endinterface

`default_nettype wire

//--- axi_read_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module axi_read_arbiter (
	input logic        clk,
	input logic        rst,
	axi_lite_if.slave  ifu,
	axi_lite_if.slave  lsu,
	axi_lite_if.master mem
);
	import mem_pkg::*;

	// one read in flight, owner kept in grant
	logic   busy;
	grant_t grant;
	grant_t last_grant;
	grant_t pick;
	logic   ar_hs;
	logic   r_hs;

	// round-robin choice while idle
	// on a tie the master not served last wins
	always_comb begin
		if (ifu.arvalid && lsu.arvalid) begin
			pick = (last_grant == gnt_ifu) ? gnt_lsu : gnt_ifu;
		end else if (lsu.arvalid) begin
			pick = gnt_lsu;
		end else begin
			pick = gnt_ifu;
		end
	end

	// ar channel
	// nothing new goes out while a response is pending
	assign mem.arvalid = !busy && ((pick == gnt_lsu) ? lsu.arvalid : ifu.arvalid);
	assign mem.araddr  = (pick == gnt_lsu) ? lsu.araddr : ifu.araddr;

	// ready only to the picked master, and only with its own valid up
	assign ifu.arready = !busy && (pick == gnt_ifu) && ifu.arvalid && mem.arready;
	assign lsu.arready = !busy && (pick == gnt_lsu) && lsu.arvalid && mem.arready;

	assign ar_hs = mem.arvalid && mem.arready;

	// r channel, steered by the held grant
	assign mem.rready = busy && ((grant == gnt_lsu) ? lsu.rready : ifu.rready);
	assign ifu.rvalid = busy && (grant == gnt_ifu) && mem.rvalid;
	assign lsu.rvalid = busy && (grant == gnt_lsu) && mem.rvalid;

	// payload can fan out, rvalid picks the receiver
	assign ifu.rdata = mem.rdata;
	assign ifu.rresp = mem.rresp;
	assign lsu.rdata = mem.rdata;
	assign lsu.rresp = mem.rresp;

	assign r_hs = mem.rvalid && mem.rready;

	// grant bookkeeping
	// ar and r handshakes never share a cycle, busy splits them
	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			grant      <= gnt_lsu;
			// fetch wins the first tie
			last_grant <= gnt_lsu;
		end else begin
			if (ar_hs) begin
				busy       <= 1'b1;
				grant      <= pick;
				last_grant <= pick;
			end else if (r_hs) begin
				busy <= 1'b0;
			end
		end
	end

	// write path, load/store only
	assign mem.awvalid = lsu.awvalid;
	assign mem.awaddr  = lsu.awaddr;
	assign lsu.awready = mem.awready;

	assign mem.wvalid  = lsu.wvalid;
	assign mem.wdata   = lsu.wdata;
	assign mem.wstrb   = lsu.wstrb;
	assign lsu.wready  = mem.wready;

	assign lsu.bvalid  = mem.bvalid;
	assign lsu.bresp   = mem.bresp;
	assign mem.bready  = lsu.bready;

	// fetch never writes, its write side stays quiet
	assign ifu.awready = 1'b0;
	assign ifu.wready  = 1'b0;
	assign ifu.bvalid  = 1'b0;
	assign ifu.bresp   = resp_okay;

endmodule

`default_nettype wire

//--- axi_sram.sv
`timescale 1ns/100ps
`default_nettype none

module axi_sram (
	input logic       clk,
	input logic       rst,
	axi_lite_if.slave bus
);
	import mem_pkg::*;

	typedef enum logic {
		rd_idle,
		rd_resp
	} rd_state_t;

	typedef enum logic {
		wr_idle,
		wr_resp
	} wr_state_t;

	// storage, one entry per 64-bit word
	logic [data_w-1:0] mem [mem_words];

	rd_state_t rd_state;
	wr_state_t wr_state;

	logic             rd_hs;
	logic             wr_hs;
	logic             rd_in_range;
	logic             wr_in_range;
	logic [idx_w-1:0] rd_idx;
	logic [idx_w-1:0] wr_idx;

	// address decode
	// anything at or above mem_words words is out of range
	assign rd_in_range = (bus.araddr[addr_w-1:word_lsb] < mem_words);
	assign wr_in_range = (bus.awaddr[addr_w-1:word_lsb] < mem_words);
	assign rd_idx      = bus.araddr[word_lsb +: idx_w];
	assign wr_idx      = bus.awaddr[word_lsb +: idx_w];

	// read side

	// address taken only when idle
	assign bus.arready = (rd_state == rd_idle);
	assign rd_hs       = bus.arvalid && bus.arready;
	assign bus.rvalid  = (rd_state == rd_resp);

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (rd_hs) begin
						rd_state <= rd_resp;
					end
				end
				rd_resp: begin
					// hold until the master takes it
					if (bus.rready) begin
						rd_state <= rd_idle;
					end
				end
				default: begin
					rd_state <= rd_idle;
				end
			endcase
		end
	end

	// read payload, sampled at the address handshake
	// a write on the same edge lands after this sample
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			if (rd_in_range) begin
				bus.rdata <= mem[rd_idx];
				bus.rresp <= resp_okay;
			end else begin
				bus.rdata <= '0;
				bus.rresp <= resp_slverr;
			end
		end
	end

	// write side

	// address and data accepted together
	assign bus.awready = (wr_state == wr_idle) && bus.awvalid && bus.wvalid;
	assign bus.wready  = bus.awready;
	assign wr_hs       = bus.awready;
	assign bus.bvalid  = (wr_state == wr_resp);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= wr_idle;
		end else begin
			case (wr_state)
				wr_idle: begin
					if (wr_hs) begin
						wr_state <= wr_resp;
					end
				end
				wr_resp: begin
					if (bus.bready) begin
						wr_state <= wr_idle;
					end
				end
				default: begin
					wr_state <= wr_idle;
				end
			endcase
		end
	end

	// response code for the accepted write
	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bus.bresp <= wr_in_range ? resp_okay : resp_slverr;
		end
	end

	// byte-strobed array write
	// out-of-range writes leave the array alone
	always_ff @(posedge clk) begin
		if (wr_hs && wr_in_range) begin
			for (int b = 0; b < strb_w; b++) begin
				if (bus.wstrb[b]) begin
					mem[wr_idx][b*byte_w +: byte_w] <= bus.wdata[b*byte_w +: byte_w];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

	// bus widths
	localparam int unsigned addr_w = 32;
	localparam int unsigned data_w = 64;
	localparam int unsigned strb_w = data_w / 8;

	// one strobe bit per byte lane
	localparam int unsigned byte_w = 8;

	// storage size in 64-bit words, 4 KiB in total
	localparam int unsigned mem_words = 512;

	// low address bits that pick a byte inside a word
	localparam int unsigned word_lsb = $clog2(strb_w);

	// word index bits, byte address 11:3
	localparam int unsigned idx_w = $clog2(mem_words);

	// response codes
	localparam logic [1:0] resp_okay   = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

	// read grant owner in the arbiter
	typedef enum logic {
		gnt_ifu = 1'b0,
		gnt_lsu = 1'b1
	} grant_t;

endpackage

`default_nettype wire

//--- mem_subsys_assert.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_assert (
	input logic                       clk,
	input logic                       rst,
	input logic                       arready,
	input logic                       rvalid,
	input logic                       rready,
	input logic [mem_pkg::data_w-1:0] rdata,
	input logic [1:0]                 rresp,
	input logic                       awvalid,
	input logic                       awready,
	input logic                       wvalid,
	input logic                       wready,
	input logic                       bvalid,
	input logic                       bready,
	input logic [1:0]                 bresp
);

	int unsigned fail_count = 0;

	// held read response keeps its payload
	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin fail_count++; $error("read response changed before rready"); end

	// write handshake gives bvalid one cycle later
	b_after_write: assert property (@(posedge clk) disable iff (rst)
		awvalid && awready && wvalid && wready |=> bvalid)
		else begin fail_count++; $error("bvalid missing after write handshake"); end

	// held write response
	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin fail_count++; $error("write response changed before bready"); end

	// one read at a time
	ar_blocked: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> !arready)
		else begin fail_count++; $error("arready high with rvalid pending"); end

	// first cycle out of reset
	quiet_after_reset: assert property (@(posedge clk)
		$past(rst) && !rst |-> !rvalid && !bvalid)
		else begin fail_count++; $error("valid high right after reset"); end

endmodule

bind axi_sram mem_subsys_assert i_assert (
	.clk     (clk),          .rst     (rst),
	.arready (bus.arready),  .rvalid  (bus.rvalid),  .rready (bus.rready),
	.rdata   (bus.rdata),    .rresp   (bus.rresp),
	.awvalid (bus.awvalid),  .awready (bus.awready),
	.wvalid  (bus.wvalid),   .wready  (bus.wready),
	.bvalid  (bus.bvalid),   .bready  (bus.bready),  .bresp  (bus.bresp)
);

`default_nettype wire

//--- mem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
	input  logic                        clk,
	input  logic                        rst,

	// fetch master, read only
	input  logic                        ifu_arvalid,
	output logic                        ifu_arready,
	input  logic [mem_pkg::addr_w-1:0]  ifu_araddr,
	output logic                        ifu_rvalid,
	input  logic                        ifu_rready,
	output logic [mem_pkg::data_w-1:0]  ifu_rdata,
	output logic [1:0]                  ifu_rresp,

	// load/store master
	input  logic                        lsu_arvalid,
	output logic                        lsu_arready,
	input  logic [mem_pkg::addr_w-1:0]  lsu_araddr,
	output logic                        lsu_rvalid,
	input  logic                        lsu_rready,
	output logic [mem_pkg::data_w-1:0]  lsu_rdata,
	output logic [1:0]                  lsu_rresp,
	input  logic                        lsu_awvalid,
	output logic                        lsu_awready,
	input  logic [mem_pkg::addr_w-1:0]  lsu_awaddr,
	input  logic                        lsu_wvalid,
	output logic                        lsu_wready,
	input  logic [mem_pkg::data_w-1:0]  lsu_wdata,
	input  logic [mem_pkg::strb_w-1:0]  lsu_wstrb,
	output logic                        lsu_bvalid,
	input  logic                        lsu_bready,
	output logic [1:0]                  lsu_bresp
);

	axi_lite_if ifu_bus ();
	axi_lite_if lsu_bus ();
	axi_lite_if mem_bus ();

	// fetch side hookup
	assign ifu_bus.arvalid = ifu_arvalid;
	assign ifu_bus.araddr  = ifu_araddr;
	assign ifu_arready     = ifu_bus.arready;
	assign ifu_rvalid      = ifu_bus.rvalid;
	assign ifu_bus.rready  = ifu_rready;
	assign ifu_rdata       = ifu_bus.rdata;
	assign ifu_rresp       = ifu_bus.rresp;

	// no writes from fetch
	assign ifu_bus.awvalid = 1'b0;
	assign ifu_bus.awaddr  = '0;
	assign ifu_bus.wvalid  = 1'b0;
	assign ifu_bus.wdata   = '0;
	assign ifu_bus.wstrb   = '0;
	assign ifu_bus.bready  = 1'b0;

	// load/store side hookup
	assign lsu_bus.arvalid = lsu_arvalid;
	assign lsu_bus.araddr  = lsu_araddr;
	assign lsu_arready     = lsu_bus.arready;
	assign lsu_rvalid      = lsu_bus.rvalid;
	assign lsu_bus.rready  = lsu_rready;
	assign lsu_rdata       = lsu_bus.rdata;
	assign lsu_rresp       = lsu_bus.rresp;
	assign lsu_bus.awvalid = lsu_awvalid;
	assign lsu_bus.awaddr  = lsu_awaddr;
	assign lsu_awready     = lsu_bus.awready;
	assign lsu_bus.wvalid  = lsu_wvalid;
	assign lsu_bus.wdata   = lsu_wdata;
	assign lsu_bus.wstrb   = lsu_wstrb;
	assign lsu_wready      = lsu_bus.wready;
	assign lsu_bvalid      = lsu_bus.bvalid;
	assign lsu_bus.bready  = lsu_bready;
	assign lsu_bresp       = lsu_bus.bresp;

	// merge both read paths onto one bus
	axi_read_arbiter i_arbiter (
		.clk (clk),
		.rst (rst),
		.ifu (ifu_bus.slave),
		.lsu (lsu_bus.slave),
		.mem (mem_bus.master)
	);

	axi_sram i_sram (
		.clk (clk),
		.rst (rst),
		.bus (mem_bus.slave)
	);

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;
	import mem_pkg::*;

	localparam int fill_words       = 256;
	localparam int partial_count    = 64;
	localparam int oor_count        = 8;
	localparam int contention_reads = 100;
	// first byte address past the array
	localparam logic [addr_w-1:0] mem_bytes = mem_words * strb_w;
	// about ten cycles per access pair, four times over
	localparam int max_cycles = 4 * 10 *
		(fill_words + partial_count + 2 * oor_count + contention_reads);

	logic              clk;
	logic              rst;
	logic              ifu_arvalid;
	logic              ifu_arready;
	logic [addr_w-1:0] ifu_araddr;
	logic              ifu_rvalid;
	logic              ifu_rready;
	logic [data_w-1:0] ifu_rdata;
	logic [1:0]        ifu_rresp;
	logic              lsu_arvalid;
	logic              lsu_arready;
	logic [addr_w-1:0] lsu_araddr;
	logic              lsu_rvalid;
	logic              lsu_rready;
	logic [data_w-1:0] lsu_rdata;
	logic [1:0]        lsu_rresp;
	logic              lsu_awvalid;
	logic              lsu_awready;
	logic [addr_w-1:0] lsu_awaddr;
	logic              lsu_wvalid;
	logic              lsu_wready;
	logic [data_w-1:0] lsu_wdata;
	logic [strb_w-1:0] lsu_wstrb;
	logic              lsu_bvalid;
	logic              lsu_bready;
	logic [1:0]        lsu_bresp;

	// reference copy of the array
	logic [data_w-1:0] model [mem_words];
	logic [addr_w-1:0] addr;
	int                seed = 43;
	int                errors = 0;
	int                cycles = 0;
	// last read address winner, fetch goes first after reset
	logic              last_lsu = 1'b1;

	mem_subsys_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// run limit
	initial begin
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", max_cycles);
		$display("Test failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [data_w-1:0] exp,
			input logic [data_w-1:0] got);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			errors++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	// on a tie the master not served last must win
	always @(posedge clk) begin
		if (ifu_arvalid && lsu_arvalid && (ifu_arready || lsu_arready)) begin
			check_true(lsu_arready == !last_lsu, "tied read not granted round-robin");
		end
		if (ifu_arvalid && ifu_arready) begin
			last_lsu <= 1'b0;
		end else if (lsu_arvalid && lsu_arready) begin
			last_lsu <= 1'b1;
		end
	end

	// word address inside the filled range
	function automatic logic [addr_w-1:0] random_word_addr();
		logic [31:0] r;
		r = $random(seed);
		return {21'd0, r[7:0], 3'd0};
	endfunction

	// one lsu write, bready toggles at random until bvalid is taken
	task automatic write_word(input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
			input logic [strb_w-1:0] s);
		logic done;
		@(negedge clk);
		lsu_awvalid = 1'b1;
		lsu_awaddr  = a;
		lsu_wvalid  = 1'b1;
		lsu_wdata   = d;
		lsu_wstrb   = s;
		#1;
		while (!(lsu_awready && lsu_wready)) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		// strobe rule, only inside the array
		if (a < mem_bytes) begin
			for (int b = 0; b < strb_w; b++) begin
				if (s[b]) begin
					model[a[11:3]][b*8 +: 8] = d[b*8 +: 8];
				end
			end
		end
		@(negedge clk);
		lsu_awvalid = 1'b0;
		lsu_wvalid  = 1'b0;
		done = 1'b0;
		while (!done) begin
			lsu_bready = 1'($random(seed));
			done = lsu_bready && lsu_bvalid;
			if (!done) begin
				@(negedge clk);
			end
		end
		check_value("lsu_bresp", data_w'((a < mem_bytes) ? resp_okay : resp_slverr),
			data_w'(lsu_bresp));
		@(posedge clk);
		@(negedge clk);
		lsu_bready = 1'b0;
		check_true(!lsu_bvalid, "write response seen twice");
	endtask

	// one read from either master, rready at random
	// called on a falling edge, the address goes out at once
	task automatic read_word(input logic from_lsu, input logic [addr_w-1:0] a);
		logic [data_w-1:0] exp_data;
		logic [1:0]        exp_resp;
		logic              done;
		if (from_lsu) begin
			lsu_arvalid = 1'b1;
			lsu_araddr  = a;
		end else begin
			ifu_arvalid = 1'b1;
			ifu_araddr  = a;
		end
		#1;
		while (!(from_lsu ? lsu_arready : ifu_arready)) begin
			@(negedge clk);
			#1;
		end
		exp_data = (a < mem_bytes) ? model[a[11:3]] : '0;
		exp_resp = (a < mem_bytes) ? resp_okay : resp_slverr;
		@(posedge clk);
		@(negedge clk);
		if (from_lsu) begin
			lsu_arvalid = 1'b0;
		end else begin
			ifu_arvalid = 1'b0;
		end
		done = 1'b0;
		while (!done) begin
			if (from_lsu) begin
				lsu_rready = 1'($random(seed));
				done = lsu_rready && lsu_rvalid;
			end else begin
				ifu_rready = 1'($random(seed));
				done = ifu_rready && ifu_rvalid;
			end
			if (!done) begin
				@(negedge clk);
			end
		end
		check_value(from_lsu ? "lsu_rdata" : "ifu_rdata", exp_data,
			from_lsu ? lsu_rdata : ifu_rdata);
		check_value(from_lsu ? "lsu_rresp" : "ifu_rresp", data_w'(exp_resp),
			data_w'(from_lsu ? lsu_rresp : ifu_rresp));
		@(posedge clk);
		@(negedge clk);
		if (from_lsu) begin
			lsu_rready = 1'b0;
		end else begin
			ifu_rready = 1'b0;
		end
		check_true(!(from_lsu ? lsu_rvalid : ifu_rvalid), "read response seen twice");
	endtask

	initial begin
		rst         = 1'b1;
		ifu_arvalid = 1'b0;
		ifu_araddr  = '0;
		ifu_rready  = 1'b0;
		lsu_arvalid = 1'b0;
		lsu_araddr  = '0;
		lsu_rready  = 1'b0;
		lsu_awvalid = 1'b0;
		lsu_awaddr  = '0;
		lsu_wvalid  = 1'b0;
		lsu_wdata   = '0;
		lsu_wstrb   = '0;
		lsu_bready  = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		#1;
		// quiet bus before the first request
		check_true(!ifu_rvalid && !lsu_rvalid && !lsu_bvalid, "valid high after reset");
		check_true(!ifu_arready && !lsu_arready && !lsu_awready && !lsu_wready,
			"ready high after reset");

		// fill with full strobes
		for (int i = 0; i < fill_words; i++) begin
			write_word(i * strb_w, {$random(seed), $random(seed)}, '1);
		end

		// both masters at once, first tie belongs to fetch
		fork
			begin
				for (int i = 0; i < contention_reads; i++)
					read_word(1'b0, random_word_addr());
			end
			begin
				for (int i = 0; i < contention_reads; i++)
					read_word(1'b1, random_word_addr());
			end
			begin
				#1;
				check_true(ifu_arready && !lsu_arready, "first tie not granted to fetch");
			end
		join

		// read back everything through fetch
		for (int i = 0; i < fill_words; i++) begin
			read_word(1'b0, i * strb_w);
		end

		// partial strobes merge old and new bytes
		for (int i = 0; i < partial_count; i++) begin
			addr = random_word_addr();
			write_word(addr, {$random(seed), $random(seed)}, 8'($random(seed)));
			read_word(1'b1, addr);
		end

		// outside the array, then the aliased word must be untouched
		for (int i = 0; i < oor_count; i++) begin
			addr = mem_bytes * (i + 1) + random_word_addr();
			write_word(addr, {$random(seed), $random(seed)}, '1);
			read_word(1'b1, addr);
			read_word(1'b0, addr & (mem_bytes - 1));
		end

		$display("errors: %0d data, %0d protocol", errors, i_dut.i_sram.i_assert.fail_count);
		if (errors == 0 && i_dut.i_sram.i_assert.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
mem_pkg.sv
axi_lite_if.sv
axi_sram.sv
axi_read_arbiter.sv
mem_subsys_top.sv
mem_subsys_assert.sv
tb_mem_subsys.sv
